// File: design/cmd_fsm.sv
// Command parser that decodes host bytes, accesses a memory bank and queues the response
`timescale 1ns/1ps
`default_nettype none

`include "uart_bridge_macros.svh"

module cmd_fsm import uart_bridge_pkg::*; (
    input  logic                   clk,
    input  logic                   arst_n_i,
    input  byte_t                  rx_data_i,
    input  logic                   rx_valid_i,
    input  logic                   tx_ready_i,
    output byte_t                  tx_data_o,
    output logic                   tx_valid_o,
    output logic [`BANK_COUNT-1:0] ram_stb_o,
    output logic                   ram_we_o,
    output word_addr_t             ram_addr_o,
    output word_t                  ram_wdata_o,
    input  word_t                  ram_rdata_i [`BANK_COUNT],
    input  logic [`BANK_COUNT-1:0] ram_ack_i
);

    cmd_state_e state_q;
    byte_t      opcode_q;
    bank_sel_t  bank_q;
    word_addr_t waddr_q;
    word_t      wdata_q;
    word_t      resp_q;
    logic [1:0] byte_cnt_q;
    bank_sel_t  rx_bank;
    logic       rx_bank_ok;
    logic       bank_ok;
    logic       ack_hit;
    word_t      rdata_sel;

    // Top two address bits pick the bank
    assign rx_bank    = rx_data_i[7:`WORD_ADDR_BITS];
    assign rx_bank_ok = rx_bank < bank_sel_t'(`BANK_COUNT);
    assign bank_ok    = bank_q < bank_sel_t'(`BANK_COUNT);

    always_comb begin
        rdata_sel = '0;
        for (int i = 0; i < `BANK_COUNT; i++) begin
            ram_stb_o[i] = (state_q == ST_ACCESS) && (bank_q == bank_sel_t'(i));
            if (bank_q == bank_sel_t'(i)) begin
                rdata_sel = ram_rdata_i[i];
            end
        end
    end

    assign ack_hit = |(ram_ack_i & ram_stb_o);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q    <= ST_OPCODE;
            opcode_q   <= '0;
            byte_cnt_q <= '0;
        end else begin
            case (state_q)
                ST_OPCODE: begin
                    if (rx_valid_i) begin
                        opcode_q <= rx_data_i;
                        state_q  <= ST_ADDR;
                    end
                end
                ST_ADDR: begin
                    if (rx_valid_i) begin
                        byte_cnt_q <= '0;
                        if (opcode_q == `OPCODE_WRITE) begin
                            state_q <= ST_DATA;
                        end else if (opcode_q == `OPCODE_READ && rx_bank_ok) begin
                            state_q <= ST_ACCESS;
                        end else begin
                            state_q <= ST_RESP;
                        end
                    end
                end
                ST_DATA: begin
                    // Unmapped bank still consumes all four data bytes
                    if (rx_valid_i) begin
                        byte_cnt_q <= byte_cnt_q + 1'b1;
                        if (byte_cnt_q == 2'd3) begin
                            state_q <= bank_ok ? ST_ACCESS : ST_RESP;
                        end
                    end
                end
                ST_ACCESS: begin
                    if (ack_hit) begin
                        state_q    <= ST_RESP;
                        byte_cnt_q <= ram_we_o ? 2'd0 : 2'd3;
                    end
                end
                ST_RESP: begin
                    if (tx_ready_i) begin
                        if (byte_cnt_q == 2'd0) begin
                            state_q <= ST_DRAIN;
                        end else begin
                            byte_cnt_q <= byte_cnt_q - 1'b1;
                        end
                    end
                end
                ST_DRAIN: begin
                    // Wait out the last stop bit, host bytes meanwhile are lost
                    if (tx_ready_i) begin
                        state_q <= ST_OPCODE;
                    end
                end
                default: state_q <= ST_OPCODE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == ST_ADDR && rx_valid_i) begin
            bank_q  <= rx_bank;
            waddr_q <= rx_data_i[`WORD_ADDR_BITS-1:0];
            resp_q  <= {`RESP_ERR, 24'h0};
        end
        if (state_q == ST_DATA && rx_valid_i) begin
            wdata_q <= {wdata_q[23:0], rx_data_i};
        end
        if (state_q == ST_ACCESS && ack_hit) begin
            resp_q <= ram_we_o ? {`RESP_ACK, 24'h0} : rdata_sel;
        end else if (state_q == ST_RESP && tx_ready_i) begin
            resp_q <= {resp_q[23:0], 8'h00};
        end
    end

    assign tx_data_o   = resp_q[31:24];
    assign tx_valid_o  = (state_q == ST_RESP);
    assign ram_we_o    = (opcode_q == `OPCODE_WRITE);
    assign ram_addr_o  = waddr_q;
    assign ram_wdata_o = wdata_q;

endmodule

`default_nettype wire

// File: design/ram_bank.sv
// Single word-wide memory bank with registered read and one-cycle strobe acknowledge
`timescale 1ns/1ps
`default_nettype none

`include "uart_bridge_macros.svh"

module ram_bank import uart_bridge_pkg::*; (
    input  logic       clk,
    input  logic       arst_n_i,
    input  logic       stb_i,
    input  logic       we_i,
    input  word_addr_t addr_i,
    input  word_t      wdata_i,
    output word_t      rdata_o,
    output logic       ack_o
);

    localparam int DEPTH = 1 << `WORD_ADDR_BITS;

    word_t mem [DEPTH];
    logic  ack_q;

    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (stb_i && we_i) begin
            mem[addr_i] <= wdata_i;
        end
        if (stb_i && !we_i) begin
            rdata_o <= mem[addr_i];
        end
    end

    // Single pulse per strobe, master drops stb on ack
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= stb_i && !ack_q;
        end
    end

    assign ack_o = ack_q;

endmodule

`default_nettype wire

// File: design/uart_baud_timer.sv
// Bit period counter giving mid-bit and end-of-bit ticks to the UART receiver and transmitter
`timescale 1ns/1ps
`default_nettype none

`include "uart_bridge_macros.svh"

module uart_baud_timer (
    input  logic clk,
    input  logic arst_n_i,
    input  logic run_i,
    output logic half_tick_o,
    output logic bit_tick_o
);

    localparam int CNT_W = $clog2(`UART_BIT_CYCLES);
    localparam logic [CNT_W-1:0] HALF_CNT = CNT_W'(`UART_BIT_CYCLES / 2);
    localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(`UART_BIT_CYCLES - 1);

    logic [CNT_W-1:0] cnt_q;

    // Held at zero while idle so each frame starts aligned
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cnt_q <= '0;
        end else if (!run_i || cnt_q == LAST_CNT) begin
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    assign half_tick_o = run_i && (cnt_q == HALF_CNT);
    assign bit_tick_o  = run_i && (cnt_q == LAST_CNT);

endmodule

`default_nettype wire

// File: design/uart_bridge_macros.svh
// Bit timing, bank count and command byte constants shared by the bridge RTL and testbench
`ifndef UART_BRIDGE_MACROS_SVH
`define UART_BRIDGE_MACROS_SVH

// Clock cycles per serial bit
`define UART_BIT_CYCLES 16

// Populated memory banks, bank 3 stays unmapped
`define BANK_COUNT 3
`define WORD_ADDR_BITS 6

// Command opcodes
`define OPCODE_READ 8'h10
`define OPCODE_WRITE 8'h20

// Response bytes
`define RESP_ACK 8'hA5
`define RESP_ERR 8'hEE

`endif

// File: design/uart_bridge_pkg.sv
// Common vector types and command state encoding, imported by the bridge modules
`default_nettype none

`include "uart_bridge_macros.svh"

package uart_bridge_pkg;

    typedef logic [7:0] byte_t;
    typedef logic [31:0] word_t;
    typedef logic [`WORD_ADDR_BITS-1:0] word_addr_t;
    typedef logic [1:0] bank_sel_t;

    // Command layer states
    typedef enum logic [2:0] {
        ST_OPCODE,
        ST_ADDR,
        ST_DATA,
        ST_ACCESS,
        ST_RESP,
        ST_DRAIN
    } cmd_state_e;

endpackage

`default_nettype wire

// File: design/uart_bridge_top.sv
// Top level of the UART to memory bridge, connects the serial port, command FSM and banks
`timescale 1ns/1ps
`default_nettype none

`include "uart_bridge_macros.svh"

module uart_bridge_top import uart_bridge_pkg::*; (
    input  logic clk,
    input  logic arst_n_i,
    input  logic uart_rxd_i,
    output logic uart_txd_o
);

    // Receiver to command layer
    byte_t rx_data;
    logic  rx_valid;

    // Command layer to transmitter
    byte_t tx_data;
    logic  tx_valid;
    logic  tx_ready;

    // Shared bank bus
    logic [`BANK_COUNT-1:0] ram_stb;
    logic                   ram_we;
    word_addr_t             ram_addr;
    word_t                  ram_wdata;
    word_t                  ram_rdata [`BANK_COUNT];
    logic [`BANK_COUNT-1:0] ram_ack;

    uart_rx u_rx (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .rxd_i     (uart_rxd_i),
        .rx_data_o (rx_data),
        .rx_valid_o(rx_valid)
    );

    uart_tx u_tx (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .tx_valid_i(tx_valid),
        .tx_data_i (tx_data),
        .tx_ready_o(tx_ready),
        .txd_o     (uart_txd_o)
    );

    cmd_fsm u_cmd (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .rx_data_i  (rx_data),
        .rx_valid_i (rx_valid),
        .tx_ready_i (tx_ready),
        .tx_data_o  (tx_data),
        .tx_valid_o (tx_valid),
        .ram_stb_o  (ram_stb),
        .ram_we_o   (ram_we),
        .ram_addr_o (ram_addr),
        .ram_wdata_o(ram_wdata),
        .ram_rdata_i(ram_rdata),
        .ram_ack_i  (ram_ack)
    );

    for (genvar g = 0; g < `BANK_COUNT; g++) begin : g_bank
        ram_bank u_bank (
            .clk     (clk),
            .arst_n_i(arst_n_i),
            .stb_i   (ram_stb[g]),
            .we_i    (ram_we),
            .addr_i  (ram_addr),
            .wdata_i (ram_wdata),
            .rdata_o (ram_rdata[g]),
            .ack_o   (ram_ack[g])
        );
    end

endmodule

`default_nettype wire

// File: design/uart_rx.sv
// 8N1 serial receiver, samples each bit at its middle and pulses a valid per good byte
`timescale 1ns/1ps
`default_nettype none

module uart_rx import uart_bridge_pkg::*; (
    input  logic  clk,
    input  logic  arst_n_i,
    input  logic  rxd_i,
    output byte_t rx_data_o,
    output logic  rx_valid_o
);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_e;

    rx_state_e  state_q;
    logic       rxd_meta_q;
    logic       rxd_sync_q;
    logic       rxd_prev_q;
    logic [2:0] bit_cnt_q;
    byte_t      shift_q;
    logic       valid_q;
    logic       half_tick;

    // Sampling happens mid-bit only
    uart_baud_timer u_timer (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .run_i      (state_q != RX_IDLE),
        .half_tick_o(half_tick),
        .bit_tick_o ()
    );

    // Two-flop synchronizer, line idles high
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rxd_meta_q <= 1'b1;
            rxd_sync_q <= 1'b1;
            rxd_prev_q <= 1'b1;
        end else begin
            rxd_meta_q <= rxd_i;
            rxd_sync_q <= rxd_meta_q;
            rxd_prev_q <= rxd_sync_q;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q   <= RX_IDLE;
            bit_cnt_q <= '0;
            valid_q   <= 1'b0;
        end else begin
            valid_q <= 1'b0;
            case (state_q)
                RX_IDLE: begin
                    if (rxd_prev_q && !rxd_sync_q) begin
                        state_q <= RX_START;
                    end
                end
                RX_START: begin
                    // Glitch shorter than half a bit counts as a false start
                    if (half_tick) begin
                        state_q   <= rxd_sync_q ? RX_IDLE : RX_DATA;
                        bit_cnt_q <= '0;
                    end
                end
                RX_DATA: begin
                    if (half_tick) begin
                        bit_cnt_q <= bit_cnt_q + 1'b1;
                        if (bit_cnt_q == 3'd7) begin
                            state_q <= RX_STOP;
                        end
                    end
                end
                RX_STOP: begin
                    if (half_tick) begin
                        valid_q <= rxd_sync_q;
                        state_q <= RX_IDLE;
                    end
                end
                default: state_q <= RX_IDLE;
            endcase
        end
    end

    // LSB arrives first
    always_ff @(posedge clk) begin
        if (state_q == RX_DATA && half_tick) begin
            shift_q <= {rxd_sync_q, shift_q[7:1]};
        end
    end

    assign rx_data_o  = shift_q;
    assign rx_valid_o = valid_q;

endmodule

`default_nettype wire

// File: design/uart_tx.sv
// 8N1 serial transmitter taking one byte per valid/ready handshake
`timescale 1ns/1ps
`default_nettype none

module uart_tx import uart_bridge_pkg::*; (
    input  logic  clk,
    input  logic  arst_n_i,
    input  logic  tx_valid_i,
    input  byte_t tx_data_i,
    output logic  tx_ready_o,
    output logic  txd_o
);

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_e;

    tx_state_e  state_q;
    logic [2:0] bit_cnt_q;
    byte_t      shift_q;
    logic       txd_q;
    logic       bit_tick;

    // Bits change on the end-of-bit tick only
    uart_baud_timer u_timer (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .run_i      (state_q != TX_IDLE),
        .half_tick_o(),
        .bit_tick_o (bit_tick)
    );

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q   <= TX_IDLE;
            bit_cnt_q <= '0;
            txd_q     <= 1'b1;
        end else begin
            case (state_q)
                TX_IDLE: begin
                    if (tx_valid_i) begin
                        state_q <= TX_START;
                        txd_q   <= 1'b0;
                    end
                end
                TX_START: begin
                    if (bit_tick) begin
                        state_q   <= TX_DATA;
                        bit_cnt_q <= '0;
                        txd_q     <= shift_q[0];
                    end
                end
                TX_DATA: begin
                    if (bit_tick) begin
                        bit_cnt_q <= bit_cnt_q + 1'b1;
                        if (bit_cnt_q == 3'd7) begin
                            state_q <= TX_STOP;
                            txd_q   <= 1'b1;
                        end else begin
                            txd_q <= shift_q[0];
                        end
                    end
                end
                TX_STOP: begin
                    if (bit_tick) begin
                        state_q <= TX_IDLE;
                    end
                end
                default: state_q <= TX_IDLE;
            endcase
        end
    end

    // Byte shifted out LSB first
    always_ff @(posedge clk) begin
        if (state_q == TX_IDLE && tx_valid_i) begin
            shift_q <= tx_data_i;
        end else if (bit_tick && (state_q == TX_START || state_q == TX_DATA)) begin
            shift_q <= {1'b0, shift_q[7:1]};
        end
    end

    assign tx_ready_o = (state_q == TX_IDLE);
    assign txd_o      = txd_q;

endmodule

`default_nettype wire

// File: dv/tb_uart_bridge.sv
// Directed testbench for the UART bridge, sends serial commands and checks replies against a model
`timescale 1ns/1ps
`default_nettype none

`include "uart_bridge_macros.svh"

module tb_uart_bridge import uart_bridge_pkg::*; ();

    localparam int RX_TIMEOUT = 2000;
    localparam int IDLE_WATCH = 400;
    localparam int WORDS      = 1 << `WORD_ADDR_BITS;

    logic clk;
    logic arst_n_i;
    logic uart_rxd_i;
    logic uart_txd_o;

    int          check_count;
    int          mismatch_count;
    int          fail_count;
    logic [15:0] lfsr_q;

    // Expected bank contents, updated on every acknowledged write
    word_t model [`BANK_COUNT][WORDS];

    byte_t host_cmd [$];
    byte_t host_resp [$];

    uart_bridge_top u_dut (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .uart_rxd_i(uart_rxd_i),
        .uart_txd_o(uart_txd_o)
    );

    bind uart_bridge_top uart_bridge_asserts u_asserts (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .ram_stb_i (ram_stb),
        .rx_valid_i(rx_valid),
        .tx_valid_i(tx_valid),
        .tx_ready_i(tx_ready)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            mismatch_count++;
            $display("MISMATCH %s got=%08h exp=%08h at %0t", name, got, exp, $time);
        end
    endtask

    // Galois form, taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        logic [15:0] nxt;
        nxt = state >> 1;
        if (state[0]) begin
            nxt = nxt ^ 16'hB400;
        end
        return nxt;
    endfunction

    task automatic draw_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            value  = {value[30:0], lfsr_q[0]};
        end
    endtask

    // 8N1 frame, LSB first, called on a falling edge
    task automatic send_byte(input byte_t data);
        logic [9:0] frame;
        frame = {1'b1, data, 1'b0};
        for (int i = 0; i < 10; i++) begin
            uart_rxd_i = frame[i];
            repeat (`UART_BIT_CYCLES) @(negedge clk);
        end
    endtask

    task automatic recv_byte(output byte_t data);
        int wait_cnt;
        data     = '0;
        wait_cnt = 0;
        while (uart_txd_o !== 1'b0 && wait_cnt < RX_TIMEOUT) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (uart_txd_o !== 1'b0) begin
            fail_count++;
            $display("ERROR: no start bit on uart_txd_o within %0d cycles", RX_TIMEOUT);
        end else begin
            repeat (`UART_BIT_CYCLES / 2) @(negedge clk);
            if (uart_txd_o !== 1'b0) begin
                fail_count++;
                $display("ERROR: start bit on uart_txd_o is gone at mid-bit, %0t", $time);
            end
            for (int i = 0; i < 8; i++) begin
                repeat (`UART_BIT_CYCLES) @(negedge clk);
                data[i] = uart_txd_o;
            end
            repeat (`UART_BIT_CYCLES) @(negedge clk);
            if (uart_txd_o !== 1'b1) begin
                fail_count++;
                $display("ERROR: bad stop bit on uart_txd_o at %0t", $time);
            end
        end
    endtask

    // Sends host_cmd while collecting resp_len reply bytes into host_resp
    task automatic run_command(input int resp_len);
        byte_t rx_byte;
        int    low_cycles;
        host_resp.delete();
        low_cycles = 0;
        fork
            begin
                foreach (host_cmd[i]) begin
                    send_byte(host_cmd[i]);
                end
            end
            begin
                for (int n = 0; n < resp_len; n++) begin
                    recv_byte(rx_byte);
                    host_resp.push_back(rx_byte);
                end
            end
        join
        // Line must stay idle once the reply is complete
        for (int i = 0; i < 2 * `UART_BIT_CYCLES; i++) begin
            @(negedge clk);
            if (uart_txd_o !== 1'b1) begin
                low_cycles++;
            end
        end
        if (low_cycles != 0) begin
            fail_count++;
            $display("ERROR: uart_txd_o active after the expected %0d reply bytes", resp_len);
        end
    endtask

    task automatic write_word(input bank_sel_t bank, input word_addr_t addr, input word_t data);
        host_cmd.delete();
        host_cmd.push_back(`OPCODE_WRITE);
        host_cmd.push_back({bank, addr});
        host_cmd.push_back(data[31:24]);
        host_cmd.push_back(data[23:16]);
        host_cmd.push_back(data[15:8]);
        host_cmd.push_back(data[7:0]);
        run_command(1);
        if (int'(bank) < `BANK_COUNT) begin
            compare_value($sformatf("uart_txd_o write ack bank %0d addr %0d", bank, addr),
                          32'(host_resp[0]), 32'(`RESP_ACK));
            model[bank][addr] = data;
        end else begin
            compare_value($sformatf("uart_txd_o write err bank %0d addr %0d", bank, addr),
                          32'(host_resp[0]), 32'(`RESP_ERR));
        end
    endtask

    task automatic read_word(input bank_sel_t bank, input word_addr_t addr);
        word_t got;
        host_cmd.delete();
        host_cmd.push_back(`OPCODE_READ);
        host_cmd.push_back({bank, addr});
        if (int'(bank) < `BANK_COUNT) begin
            run_command(4);
            got = {host_resp[0], host_resp[1], host_resp[2], host_resp[3]};
            compare_value($sformatf("uart_txd_o read data bank %0d addr %0d", bank, addr),
                          got, model[bank][addr]);
        end else begin
            run_command(1);
            compare_value($sformatf("uart_txd_o read err bank %0d addr %0d", bank, addr),
                          32'(host_resp[0]), 32'(`RESP_ERR));
        end
    endtask

    task automatic idle_after_reset();
        int low_cycles;
        low_cycles = 0;
        for (int i = 0; i < IDLE_WATCH; i++) begin
            @(negedge clk);
            if (uart_txd_o !== 1'b1) begin
                low_cycles++;
            end
        end
        compare_value("uart_txd_o low cycles after reset", low_cycles, 32'd0);
        read_word(2'd0, 6'd5);
    endtask

    task automatic write_then_read();
        write_word(2'd1, 6'd10, 32'hDEAD_BEEF);
        read_word(2'd1, 6'd10);
    endtask

    task automatic banks_independent();
        write_word(2'd0, 6'd20, 32'h0102_0304);
        write_word(2'd1, 6'd20, 32'hA0B0_C0D0);
        write_word(2'd2, 6'd20, 32'h5566_7788);
        read_word(2'd0, 6'd20);
        read_word(2'd1, 6'd20);
        read_word(2'd2, 6'd20);
    endtask

    // Bank 3 has no memory, bank 0 at the same word must keep its data
    task automatic unmapped_bank_errors();
        write_word(2'd3, 6'd20, 32'h1234_5678);
        read_word(2'd3, 6'd20);
        read_word(2'd0, 6'd20);
    endtask

    task automatic unknown_opcode_errors();
        host_cmd.delete();
        host_cmd.push_back(8'h5A);
        host_cmd.push_back({2'd1, 6'd10});
        run_command(1);
        compare_value("uart_txd_o unknown opcode err", 32'(host_resp[0]), 32'(`RESP_ERR));
        read_word(2'd1, 6'd10);
    endtask

    task automatic random_words_readback();
        bank_sel_t   bank_list [8];
        word_addr_t  addr_list [8];
        logic [31:0] value;
        for (int i = 0; i < 8; i++) begin
            draw_bits(2, value);
            bank_list[i] = bank_sel_t'(value % 3);
            draw_bits(`WORD_ADDR_BITS, value);
            addr_list[i] = word_addr_t'(value);
            draw_bits(32, value);
            write_word(bank_list[i], addr_list[i], value);
        end
        for (int i = 0; i < 8; i++) begin
            read_word(bank_list[i], addr_list[i]);
        end
    endtask

    initial begin
        arst_n_i       = 1'b0;
        uart_rxd_i     = 1'b1;
        check_count    = 0;
        mismatch_count = 0;
        fail_count     = 0;
        lfsr_q         = 16'd75;
        for (int b = 0; b < `BANK_COUNT; b++) begin
            for (int a = 0; a < WORDS; a++) begin
                model[b][a] = '0;
            end
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        arst_n_i = 1'b1;

        idle_after_reset();
        write_then_read();
        banks_independent();
        unmapped_bank_errors();
        unknown_opcode_errors();
        random_words_readback();

        $display("checks=%0d mismatches=%0d other_errors=%0d",
                 check_count, mismatch_count, fail_count);
        if (mismatch_count == 0 && fail_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: dv/uart_bridge_asserts.sv
// Concurrent checks on the bridge's internal handshakes, bound into the top level by the testbench
`timescale 1ns/1ps
`default_nettype none

`include "uart_bridge_macros.svh"

module uart_bridge_asserts (
    input logic                   clk,
    input logic                   arst_n_i,
    input logic [`BANK_COUNT-1:0] ram_stb_i,
    input logic                   rx_valid_i,
    input logic                   tx_valid_i,
    input logic                   tx_ready_i
);

    // Banks share one address and data bus
    a_single_stb: assert property (@(posedge clk) disable iff (!arst_n_i)
        $onehot0(ram_stb_i))
        else $error("more than one ram_stb high: %b", ram_stb_i);

    a_rx_pulse: assert property (@(posedge clk) disable iff (!arst_n_i)
        rx_valid_i |=> !rx_valid_i)
        else $error("rx_valid held for more than one cycle");

    // Response byte must wait for the transmitter
    a_tx_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
        (tx_valid_i && !tx_ready_i) |=> tx_valid_i)
        else $error("tx_valid dropped before tx_ready was seen");

endmodule

`default_nettype wire

// File: flist.f
+incdir+design
design/uart_bridge_pkg.sv
design/uart_baud_timer.sv
design/uart_rx.sv
design/uart_tx.sv
design/ram_bank.sv
design/cmd_fsm.sv
design/uart_bridge_top.sv
dv/uart_bridge_asserts.sv
dv/tb_uart_bridge.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_uart_bridge -f flist.f -o sim_uart_bridge

./obj_dir/sim_uart_bridge | tee sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
    echo "PASS"
else
    echo "FAIL: see sim.log"
    exit 1
fi
